// ==== alu_core_top.f ====
+incdir+verilog
+incdir+test
verilog/alu_core_pkg.sv
verilog/insn_decode.sv
verilog/operand_read.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/alu_core_top.sv
test/alu_core_tb.sv

// ==== test/alu_core_ref.svh ====
`ifndef ALU_CORE_REF_SVH
`define ALU_CORE_REF_SVH

`include "alu_core_config.svh"

alu_core_pkg::data_t  model_regs [`ALU_REG_COUNT];
alu_core_pkg::flags_t model_flags;

function automatic void model_reset();
  for (int i = 0; i < `ALU_REG_COUNT; i++) begin
    model_regs[i] = '0;
  end
  model_flags = '0;
endfunction

function automatic logic cond_holds(input logic [3:0] cond, input alu_core_pkg::flags_t f);
  logic c, o, s, z;
  {c, o, s, z} = f;
  case (cond)
    4'd0:    return z;
    4'd1:    return !z;
    4'd2:    return c;
    4'd3:    return !c;
    4'd4:    return s;
    4'd5:    return !s;
    4'd6:    return o;
    4'd7:    return !o;
    4'd8:    return c && !z;
    4'd9:    return !c || z;
    4'd10:   return s == o;
    4'd11:   return s != o;
    4'd12:   return !z && (s == o);
    4'd13:   return z || (s != o);
    4'd14:   return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// runs one instruction in program order on the model state
function automatic void model_step(input alu_core_pkg::insn_t w, output logic written,
                                   output alu_core_pkg::data_t res,
                                   output alu_core_pkg::flags_t flags);
  alu_core_pkg::data_t a;
  alu_core_pkg::data_t b;
  alu_core_pkg::data_t imm;
  logic [5:0]          sh;
  logic                c, o;
  a      = model_regs[w[19:16]];
  b      = model_regs[w[15:12]];
  imm    = {{(`ALU_DATA_W-`ALU_IMM_W){w[11]}}, w[11:0]};
  sh     = b[5:0];
  {c, o} = model_flags[3:2];
  res    = '0;
  case (w[31:28])
    4'd0: begin
      {c, res} = a + b; // carry out of the 65-bit sum
      o = (a[63] == b[63]) && (res[63] != a[63]);
    end
    4'd1: begin
      res = a - b;
      c   = (a >= b); // carry set means no borrow
      o   = (a[63] != b[63]) && (res[63] != a[63]);
    end
    4'd2: begin
      {c, res} = a + imm;
      o = (a[63] == imm[63]) && (res[63] != a[63]);
    end
    4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8: begin
      c = 1'b0;
      o = 1'b0;
      case (w[31:28])
        4'd3:    res = a & b;
        4'd4:    res = a | b;
        4'd5:    res = a ^ b;
        4'd6:    res = a << sh;
        4'd7:    res = a >> sh;
        default: res = (a >> sh) | (a[63] ? ~({`ALU_DATA_W{1'b1}} >> sh) : '0);
      endcase
    end
    4'd9: begin
      case (w[1:0])
        2'd0:    res = {{56{a[7]}}, a[7:0]};
        2'd1:    res = {{48{a[15]}}, a[15:0]};
        2'd2:    res = {{32{a[31]}}, a[31:0]};
        default: res = {32'd0, a[7:0], a[15:8], a[23:16], a[31:24]};
      endcase
    end
    4'd10:   res = imm;
    default: res = '0; // nop codes
  endcase
  written = (w[31:28] <= 4'd10) && cond_holds(w[27:24], model_flags);
  if (written) begin
    model_regs[w[23:20]] = res;
    model_flags = {c, o, res[`ALU_DATA_W-1], res == '0};
  end
  flags = model_flags;
endfunction

`endif

// ==== test/alu_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_core_config.svh"

module alu_core_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 8;
  localparam int TOTAL_INSNS = 16 + 225 + 30 + 24 + 225 + 40 + 144 + 200;
  // up to four cycles per instruction with its gap plus ten per test to drain
  localparam int MAX_CYCLES  = RST_CYCLES + 4 * TOTAL_INSNS + 10 * 6 + 50;

  typedef struct packed {
    logic [63:0]            due;
    logic                   written;
    alu_core_pkg::reg_idx_t dest;
    alu_core_pkg::data_t    data;
    alu_core_pkg::flags_t   flags;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   insn_valid;
  alu_core_pkg::insn_t    insn;
  logic                   result_valid;
  logic                   result_written;
  alu_core_pkg::reg_idx_t result_reg;
  alu_core_pkg::data_t    result_data;
  alu_core_pkg::flags_t   result_flags;

  expect_t exp_q [$];
  expect_t want;
  integer  seed = 32'hfa79;
  int      cycles = 0;
  int      errors = 0;
  int      errors_before = 0;
  int      tests_ok = 0;
  int      tests_bad = 0;

  `include "alu_core_ref.svh"

  alu_core_top alu_core_top_inst (
    .clk, .rst, .insn_valid, .insn,
    .result_valid, .result_written, .result_reg, .result_data, .result_flags
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
      $display("Regression failed");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v, got_v);
    $display("FAILED t=%0t %s expected %h got %h", $time, sig, exp_v, got_v);
    errors++;
  endtask

  // one strobe followed by gap idle cycles
  task automatic issue(input logic [3:0] op, cond, rd, ra, rb, input logic [11:0] imm,
                       input int gap);
    expect_t e;
    alu_core_pkg::insn_t w;
    w = {op, cond, rd, ra, rb, imm};
    @(posedge clk);
    insn_valid <= 1'b1;
    insn       <= w;
    e.due  = $time + 3 * CLK_PERIOD;
    e.dest = rd;
    model_step(w, e.written, e.data, e.flags);
    exp_q.push_back(e);
    repeat (gap) begin
      @(posedge clk);
      insn_valid <= 1'b0;
    end
  endtask

  // wide random values in r0..r13 while r15 holds the shift step
  task automatic scramble_regs();
    issue(alu_core_pkg::OP_MOVI, alu_core_pkg::COND_AL, 15, 0, 0, 11, 0);
    for (int r = 0; r < 14; r++) begin
      issue(alu_core_pkg::OP_MOVI, alu_core_pkg::COND_AL, r, 0, 0, rand_below(4096), 0);
      for (int k = 0; k < 5; k++) begin
        issue(alu_core_pkg::OP_SHL, alu_core_pkg::COND_AL, r, r, 15, 0, 0);
        issue(alu_core_pkg::OP_MOVI, alu_core_pkg::COND_AL, 14, 0, 0, rand_below(4096), 0);
        issue(alu_core_pkg::OP_XOR, alu_core_pkg::COND_AL, r, r, 14, 0, 0);
      end
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    @(posedge clk);
    insn_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    n = errors - errors_before;
    errors_before = errors;
    if (n == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, n);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("error t=%0t: result_valid with no instruction outstanding", $time);
        errors++;
      end else begin
        want = exp_q.pop_front();
        if ($time - CLK_PERIOD / 2 != want.due)
          report_mismatch("result_valid time", want.due, $time - CLK_PERIOD / 2);
        if (result_written !== want.written)
          report_mismatch("result_written", want.written, result_written);
        if (result_reg !== want.dest)
          report_mismatch("result_reg", want.dest, result_reg);
        if (want.written && result_data !== want.data)
          report_mismatch("result_data", want.data, result_data);
        if (result_flags !== want.flags)
          report_mismatch("result_flags", want.flags, result_flags);
      end
    end
  end

  initial begin
    int d;
    int s;
    int prev;
    int cnd;
    rst        = 1'b1;
    insn_valid = 1'b0;
    insn       = '0;
    model_reset();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    for (int r = 0; r < 16; r++) begin
      issue(alu_core_pkg::OP_MOVI, alu_core_pkg::COND_AL, r, 0, 0, rand_below(4096), 1);
    end
    finish_test("movi_latency");

    scramble_regs();
    for (int i = 0; i < 30; i++) begin
      // codes 0..2 are add, sub, addi
      issue(rand_below(3), alu_core_pkg::COND_AL, rand_below(14), rand_below(14),
            rand_below(14), rand_below(4096), 1);
    end
    finish_test("add_sub_addi");

    prev = rand_below(14);
    for (int i = 0; i < 24; i++) begin
      d = rand_below(14);
      s = (i % 2) ? prev : rand_below(14);
      issue(rand_below(11), alu_core_pkg::COND_AL, d, prev, s, rand_below(4096), 0);
      prev = d;
    end
    finish_test("forwarding");

    scramble_regs();
    for (int op = 3; op <= 8; op++) begin // and, or, xor, shl, shr, sar
      for (int k = 0; k < 4; k++) begin
        issue(op, alu_core_pkg::COND_AL, rand_below(14), rand_below(14), rand_below(14),
              rand_below(4096), rand_below(2));
      end
    end
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 4; k++) begin
        issue(alu_core_pkg::OP_SXT, alu_core_pkg::COND_AL, rand_below(14), rand_below(14),
              0, m, rand_below(2));
      end
    end
    finish_test("logic_shift_sxt");

    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 3; k++) begin
        d = rand_below(14);
        s = rand_below(14);
        if (k == 1) begin
          issue(alu_core_pkg::OP_SUB, alu_core_pkg::COND_AL, rand_below(14), s, s, 0, 0);
        end else begin
          issue(rand_below(6), alu_core_pkg::COND_AL, rand_below(14), rand_below(14),
                rand_below(14), rand_below(4096), 0);
        end
        issue(alu_core_pkg::OP_ADDI, c, d, s, 0, rand_below(4096), 0);
        issue(alu_core_pkg::OP_OR, alu_core_pkg::COND_AL, d, d, d, 0, 1); // read d back
      end
    end
    finish_test("conditions");

    for (int i = 0; i < 200; i++) begin
      cnd = rand_below(2) ? int'(alu_core_pkg::COND_AL) : rand_below(16);
      issue(rand_below(16), cnd, rand_below(16), rand_below(16), rand_below(16),
            rand_below(4096), rand_below(4));
    end
    finish_test("random_stream");

    repeat (4) @(posedge clk); // catch stray strobes
    $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/alu_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_core_top (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      insn_valid,
  input  wire alu_core_pkg::insn_t insn,
  output logic                     result_valid,
  output logic                     result_written,
  output alu_core_pkg::reg_idx_t   result_reg,
  output alu_core_pkg::data_t      result_data,
  output alu_core_pkg::flags_t     result_flags
);

  logic                   dec_valid;
  alu_core_pkg::op_t      dec_op;
  alu_core_pkg::cond_t    dec_cond;
  alu_core_pkg::reg_idx_t dec_rd, dec_ra, dec_rb;
  alu_core_pkg::data_t    dec_imm;

  logic                   rd_valid;
  alu_core_pkg::op_t      rd_op;
  alu_core_pkg::cond_t    rd_cond;
  alu_core_pkg::reg_idx_t rd_dest;
  alu_core_pkg::data_t    opnd_a, opnd_b, rd_imm;

  logic                   ex_valid, ex_write;
  alu_core_pkg::reg_idx_t ex_dest;
  alu_core_pkg::data_t    ex_data;
  alu_core_pkg::flags_t   ex_flags;

  logic                   wb_write;
  alu_core_pkg::reg_idx_t wb_dest;
  alu_core_pkg::data_t    wb_data;
  alu_core_pkg::flags_t   cur_flags;

  insn_decode insn_decode_inst (
    .clk, .rst, .insn_valid, .insn,
    .dec_valid, .dec_op, .dec_cond, .dec_rd, .dec_ra, .dec_rb, .dec_imm
  );

  operand_read operand_read_inst (
    .clk, .rst,
    .dec_valid, .dec_op, .dec_cond, .dec_rd, .dec_ra, .dec_rb, .dec_imm,
    .ex_valid, .ex_write, .ex_dest, .ex_data, // forward path
    .wb_write, .wb_dest, .wb_data,
    .rd_valid, .rd_op, .rd_cond, .rd_dest, .opnd_a, .opnd_b, .rd_imm
  );

  alu_execute alu_execute_inst (
    .rd_valid, .rd_op, .rd_cond, .rd_dest, .opnd_a, .opnd_b, .rd_imm, .cur_flags,
    .ex_valid, .ex_write, .ex_dest, .ex_data, .ex_flags
  );

  result_writeback result_writeback_inst (
    .clk, .rst,
    .ex_valid, .ex_write, .ex_dest, .ex_data, .ex_flags,
    .wb_write, .wb_dest, .wb_data, .cur_flags,
    .result_valid, .result_written, .result_reg, .result_data, .result_flags
  );

endmodule

`default_nettype wire

// ==== verilog/result_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_writeback (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         ex_valid,
  input  wire                         ex_write,
  input  wire alu_core_pkg::reg_idx_t ex_dest,
  input  wire alu_core_pkg::data_t    ex_data,
  input  wire alu_core_pkg::flags_t   ex_flags,
  output logic                        wb_write,
  output alu_core_pkg::reg_idx_t      wb_dest,
  output alu_core_pkg::data_t         wb_data,
  output alu_core_pkg::flags_t        cur_flags,
  output logic                        result_valid,
  output logic                        result_written,
  output alu_core_pkg::reg_idx_t      result_reg,
  output alu_core_pkg::data_t         result_data,
  output alu_core_pkg::flags_t        result_flags
);

  // register file takes the write on the same edge as the result regs
  assign wb_write = ex_write;
  assign wb_dest  = ex_dest;
  assign wb_data  = ex_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      cur_flags <= '0;
    end else if (ex_write) begin
      cur_flags <= ex_flags; // failed cond or nop leaves flags alone
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid   <= 1'b0;
      result_written <= 1'b0;
    end else begin
      result_valid   <= ex_valid;
      result_written <= ex_write;
    end
  end

  always_ff @(posedge clk) begin
    result_reg  <= ex_dest;
    result_data <= ex_data;
  end

  assign result_flags = cur_flags; // state after this instruction

endmodule

`default_nettype wire

// ==== verilog/alu_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_core_config.svh"

module alu_execute (
  input  wire                         rd_valid,
  input  wire alu_core_pkg::op_t      rd_op,
  input  wire alu_core_pkg::cond_t    rd_cond,
  input  wire alu_core_pkg::reg_idx_t rd_dest,
  input  wire alu_core_pkg::data_t    opnd_a,
  input  wire alu_core_pkg::data_t    opnd_b,
  input  wire alu_core_pkg::data_t    rd_imm,
  input  wire alu_core_pkg::flags_t   cur_flags,
  output logic                        ex_valid,
  output logic                        ex_write,
  output alu_core_pkg::reg_idx_t      ex_dest,
  output alu_core_pkg::data_t         ex_data,
  output alu_core_pkg::flags_t        ex_flags
);

  logic                   fc, fo, fs, fz;
  logic                   cond_ok;
  alu_core_pkg::data_t    add_b;
  logic                   add_cin;
  logic [`ALU_DATA_W:0]   add_sum;
  logic                   add_ovf;
  logic [`ALU_SHIFT_W-1:0] shamt;
  alu_core_pkg::data_t    sxt_val;
  alu_core_pkg::data_t    res;
  logic                   c_out, o_out;

  assign {fc, fo, fs, fz} = cur_flags;

  always_comb begin
    case (rd_cond)
      alu_core_pkg::COND_EQ: cond_ok = fz;
      alu_core_pkg::COND_NE: cond_ok = !fz;
      alu_core_pkg::COND_CS: cond_ok = fc;
      alu_core_pkg::COND_CC: cond_ok = !fc;
      alu_core_pkg::COND_MI: cond_ok = fs;
      alu_core_pkg::COND_PL: cond_ok = !fs;
      alu_core_pkg::COND_VS: cond_ok = fo;
      alu_core_pkg::COND_VC: cond_ok = !fo;
      alu_core_pkg::COND_HI: cond_ok = fc && !fz;
      alu_core_pkg::COND_LS: cond_ok = !fc || fz;
      alu_core_pkg::COND_GE: cond_ok = (fs == fo);
      alu_core_pkg::COND_LT: cond_ok = (fs != fo);
      alu_core_pkg::COND_GT: cond_ok = !fz && (fs == fo);
      alu_core_pkg::COND_LE: cond_ok = fz || (fs != fo);
      alu_core_pkg::COND_AL: cond_ok = 1'b1;
      default:               cond_ok = 1'b0; // nv
    endcase
  end

  // one adder for add, sub and addi
  always_comb begin
    add_b   = opnd_b;
    add_cin = 1'b0;
    if (rd_op == alu_core_pkg::OP_SUB) begin
      add_b   = ~opnd_b;
      add_cin = 1'b1;
    end else if (rd_op == alu_core_pkg::OP_ADDI) begin
      add_b = rd_imm;
    end
  end

  assign add_sum = {1'b0, opnd_a} + {1'b0, add_b} + {{`ALU_DATA_W{1'b0}}, add_cin};
  assign add_ovf = (opnd_a[`ALU_DATA_W-1] == add_b[`ALU_DATA_W-1]) &&
                   (add_sum[`ALU_DATA_W-1] != opnd_a[`ALU_DATA_W-1]);

  assign shamt = opnd_b[`ALU_SHIFT_W-1:0];

  always_comb begin
    case (rd_imm[1:0])
      2'd0:    sxt_val = {{56{opnd_a[7]}}, opnd_a[7:0]};
      2'd1:    sxt_val = {{48{opnd_a[15]}}, opnd_a[15:0]};
      2'd2:    sxt_val = {{32{opnd_a[31]}}, opnd_a[31:0]};
      default: sxt_val = {32'b0, opnd_a[7:0], opnd_a[15:8], opnd_a[23:16], opnd_a[31:24]};
    endcase
  end

  always_comb begin
    res   = '0;
    c_out = fc; // kept unless the group sets it
    o_out = fo;
    case (rd_op)
      alu_core_pkg::OP_ADD,
      alu_core_pkg::OP_SUB,
      alu_core_pkg::OP_ADDI: begin
        res   = add_sum[`ALU_DATA_W-1:0];
        c_out = add_sum[`ALU_DATA_W];
        o_out = add_ovf;
      end
      alu_core_pkg::OP_AND: begin
        res   = opnd_a & opnd_b;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_OR: begin
        res   = opnd_a | opnd_b;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_XOR: begin
        res   = opnd_a ^ opnd_b;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_SHL: begin
        res   = opnd_a << shamt;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_SHR: begin
        res   = opnd_a >> shamt;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_SAR: begin
        res   = $signed(opnd_a) >>> shamt;
        c_out = 1'b0;
        o_out = 1'b0;
      end
      alu_core_pkg::OP_SXT:  res = sxt_val;
      alu_core_pkg::OP_MOVI: res = rd_imm;
      default:               res = '0;
    endcase
  end

  assign ex_valid = rd_valid;
  assign ex_write = rd_valid && cond_ok && (rd_op != alu_core_pkg::OP_NOP);
  assign ex_dest  = rd_dest;
  assign ex_data  = res;
  assign ex_flags = {c_out, o_out, res[`ALU_DATA_W-1], (res == '0)};

endmodule

`default_nettype wire

// ==== verilog/operand_read.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_core_config.svh"

module operand_read (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         dec_valid,
  input  wire alu_core_pkg::op_t      dec_op,
  input  wire alu_core_pkg::cond_t    dec_cond,
  input  wire alu_core_pkg::reg_idx_t dec_rd,
  input  wire alu_core_pkg::reg_idx_t dec_ra,
  input  wire alu_core_pkg::reg_idx_t dec_rb,
  input  wire alu_core_pkg::data_t    dec_imm,
  input  wire                         ex_valid,
  input  wire                         ex_write,
  input  wire alu_core_pkg::reg_idx_t ex_dest,
  input  wire alu_core_pkg::data_t    ex_data,
  input  wire                         wb_write,
  input  wire alu_core_pkg::reg_idx_t wb_dest,
  input  wire alu_core_pkg::data_t    wb_data,
  output logic                        rd_valid,
  output alu_core_pkg::op_t           rd_op,
  output alu_core_pkg::cond_t         rd_cond,
  output alu_core_pkg::reg_idx_t      rd_dest,
  output alu_core_pkg::data_t         opnd_a,
  output alu_core_pkg::data_t         opnd_b,
  output alu_core_pkg::data_t         rd_imm
);

  alu_core_pkg::data_t regs [`ALU_REG_COUNT];
  alu_core_pkg::data_t src_a;
  alu_core_pkg::data_t src_b;
  logic                fwd_ok;

  // instruction in execute right now is one slot ahead
  assign fwd_ok = ex_valid && ex_write;

  always_comb begin
    src_a = regs[dec_ra];
    if (fwd_ok && ex_dest == dec_ra) begin
      src_a = ex_data;
    end
  end

  always_comb begin
    src_b = regs[dec_rb];
    if (fwd_ok && ex_dest == dec_rb) begin
      src_b = ex_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ALU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb_dest] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    rd_op   <= dec_op;
    rd_cond <= dec_cond;
    rd_dest <= dec_rd;
    opnd_a  <= src_a;
    opnd_b  <= src_b;
    rd_imm  <= dec_imm;
  end

endmodule

`default_nettype wire

// ==== verilog/insn_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_core_config.svh"

module insn_decode (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      insn_valid,
  input  wire alu_core_pkg::insn_t insn,
  output logic                     dec_valid,
  output alu_core_pkg::op_t        dec_op,
  output alu_core_pkg::cond_t      dec_cond,
  output alu_core_pkg::reg_idx_t   dec_rd,
  output alu_core_pkg::reg_idx_t   dec_ra,
  output alu_core_pkg::reg_idx_t   dec_rb,
  output alu_core_pkg::data_t      dec_imm
);

  alu_core_pkg::op_t     op_map;
  alu_core_pkg::data_t   imm_ext;
  logic [`ALU_IMM_W-1:0] imm12;

  assign imm12 = insn[`ALU_IMM_W-1:0];

  // opcode field, unused codes become nop
  always_comb begin
    case (insn[31:28])
      4'd0:    op_map = alu_core_pkg::OP_ADD;
      4'd1:    op_map = alu_core_pkg::OP_SUB;
      4'd2:    op_map = alu_core_pkg::OP_ADDI;
      4'd3:    op_map = alu_core_pkg::OP_AND;
      4'd4:    op_map = alu_core_pkg::OP_OR;
      4'd5:    op_map = alu_core_pkg::OP_XOR;
      4'd6:    op_map = alu_core_pkg::OP_SHL;
      4'd7:    op_map = alu_core_pkg::OP_SHR;
      4'd8:    op_map = alu_core_pkg::OP_SAR;
      4'd9:    op_map = alu_core_pkg::OP_SXT;
      4'd10:   op_map = alu_core_pkg::OP_MOVI;
      default: op_map = alu_core_pkg::OP_NOP;
    endcase
  end

  always_comb begin
    case (op_map)
      alu_core_pkg::OP_SHL,
      alu_core_pkg::OP_SHR,
      alu_core_pkg::OP_SAR:
        imm_ext = {{(`ALU_DATA_W-`ALU_IMM_W){1'b0}}, imm12}; // raw field for shifts
      default:
        imm_ext = {{(`ALU_DATA_W-`ALU_IMM_W){imm12[`ALU_IMM_W-1]}}, imm12};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec_op   <= op_map;
    dec_cond <= alu_core_pkg::cond_t'(insn[27:24]);
    dec_rd   <= insn[23:20];
    dec_ra   <= insn[19:16];
    dec_rb   <= insn[15:12];
    dec_imm  <= imm_ext;
  end

endmodule

`default_nettype wire

// ==== verilog/alu_core_pkg.sv ====
`default_nettype none

`include "alu_core_config.svh"

package alu_core_pkg;

  typedef logic [`ALU_DATA_W-1:0]    data_t;
  typedef logic [`ALU_INSN_W-1:0]    insn_t;
  typedef logic [`ALU_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [3:0]                flags_t; // c, o, s, z from bit 3 down

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_ADDI = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SHL  = 4'd6,
    OP_SHR  = 4'd7,
    OP_SAR  = 4'd8,
    OP_SXT  = 4'd9,
    OP_MOVI = 4'd10,
    OP_NOP  = 4'd15 // codes 11..14 decode to this too
  } op_t;

  typedef enum logic [3:0] {
    COND_EQ = 4'd0,
    COND_NE = 4'd1,
    COND_CS = 4'd2,
    COND_CC = 4'd3,
    COND_MI = 4'd4,
    COND_PL = 4'd5,
    COND_VS = 4'd6,
    COND_VC = 4'd7,
    COND_HI = 4'd8,
    COND_LS = 4'd9,
    COND_GE = 4'd10,
    COND_LT = 4'd11,
    COND_GT = 4'd12,
    COND_LE = 4'd13,
    COND_AL = 4'd14,
    COND_NV = 4'd15
  } cond_t;

endpackage

`default_nettype wire

// ==== verilog/alu_core_config.svh ====
`ifndef ALU_CORE_CONFIG_SVH
`define ALU_CORE_CONFIG_SVH

// datapath and instruction word
`define ALU_DATA_W 64
`define ALU_INSN_W 32

// register file
`define ALU_REG_COUNT 16
`define ALU_REG_IDX_W 4

// immediate field of the instruction word
`define ALU_IMM_W 12

`define ALU_SHIFT_W 6 // covers 0..63

`endif
